//--- mem_pkg.sv
package mem_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // cache geometry defaults for the top level
    localparam int DEF_LINE_WORDS = 4;
    localparam int DEF_NUM_LINES  = 8;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   word_t;
    typedef logic [DATA_W/8-1:0] strb_t;

    // lower address in the low half
    typedef logic [2*DATA_W-1:0] fetch_pair_t;

    // beats minus one
    typedef logic [7:0] len_t;

    // load/store size and signedness
    typedef enum logic [2:0] {
        MT_B  = 3'b000,
        MT_H  = 3'b001,
        MT_W  = 3'b010,
        MT_BU = 3'b100,
        MT_HU = 3'b101
    } mem_type_e;

endpackage

//--- icache.sv
`timescale 1ns/1ps

module icache
    import mem_pkg::*;
#(
    parameter int LINE_WORDS = DEF_LINE_WORDS,
    parameter int NUM_LINES  = DEF_NUM_LINES
) (
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_if_req,
    input  addr_t       i_if_addr,
    output logic        o_if_valid,
    output fetch_pair_t o_if_data,
    output logic        o_ic_arvalid,
    output addr_t       o_ic_araddr,
    output len_t        o_ic_arlen,
    input  logic        i_ic_arready,
    input  logic        i_ic_rvalid,
    input  word_t       i_ic_rdata,
    input  logic        i_ic_rlast,
    output logic        o_ic_rready
);

    localparam int WOFF_W   = $clog2(LINE_WORDS);
    localparam int OFF_W    = WOFF_W + 2;
    localparam int IDX_BITS = $clog2(NUM_LINES);
    localparam int IDX_W    = (IDX_BITS > 0) ? IDX_BITS : 1;
    localparam int TAG_LSB  = OFF_W + IDX_BITS;
    localparam int TAG_W    = ADDR_W - TAG_LSB;

    typedef enum logic [1:0] {
        IC_IDLE,
        IC_LOOKUP,
        IC_REQ,
        IC_REFILL
    } ic_state_e;

    ic_state_e            state;
    addr_t                req_addr;
    logic [WOFF_W-1:0]    beat;
    logic [NUM_LINES-1:0] valid_q;
    logic [TAG_W-1:0]     tag_mem [NUM_LINES];
    word_t                data_mem [NUM_LINES][LINE_WORDS];

    logic [IDX_W-1:0]  idx;
    logic [TAG_W-1:0]  tag;
    logic [WOFF_W-1:0] woff;
    logic              hit;
    logic              r_fire;

    // a single line maps everything to index 0
    assign idx  = IDX_W'((req_addr >> OFF_W) & addr_t'(NUM_LINES - 1));
    assign tag  = req_addr[ADDR_W-1:TAG_LSB];
    assign woff = req_addr[OFF_W-1:2];
    assign hit  = valid_q[idx] && (tag_mem[idx] == tag);

    assign r_fire = i_ic_rvalid && o_ic_rready;

    // pair is 8-byte aligned so the odd word stays in the line
    assign o_if_valid = (state == IC_LOOKUP) && hit;
    assign o_if_data  = {data_mem[idx][woff | WOFF_W'(1)], data_mem[idx][woff]};

    assign o_ic_arvalid = (state == IC_REQ);
    assign o_ic_araddr  = {req_addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    assign o_ic_arlen   = len_t'(LINE_WORDS - 1);
    assign o_ic_rready  = (state == IC_REFILL);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= IC_IDLE;
            valid_q <= '0;
            beat    <= '0;
        end else begin
            case (state)
                IC_IDLE: begin
                    if (i_if_req) begin
                        state <= IC_LOOKUP;
                    end
                end
                IC_LOOKUP: begin
                    state <= hit ? IC_IDLE : IC_REQ;
                end
                IC_REQ: begin
                    beat <= '0;
                    if (i_ic_arready) begin
                        state <= IC_REFILL;
                    end
                end
                IC_REFILL: begin
                    if (r_fire) begin
                        beat <= beat + 1'b1;
                    end
                    // line complete, look up again to serve the pair
                    if (r_fire && i_ic_rlast) begin
                        valid_q[idx] <= 1'b1;
                        state        <= IC_LOOKUP;
                    end
                end
                default: begin
                    state <= IC_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IC_IDLE && i_if_req) begin
            req_addr <= i_if_addr;
        end
        if (r_fire) begin
            data_mem[idx][beat] <= i_ic_rdata;
        end
        if (r_fire && i_ic_rlast) begin
            tag_mem[idx] <= tag;
        end
    end

endmodule

//--- data_port.sv
`timescale 1ns/1ps

module data_port
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst_n,
    input  logic      i_mem_rd,
    input  logic      i_mem_wr,
    input  addr_t     i_mem_addr,
    input  mem_type_e i_mem_type,
    input  word_t     i_mem_wdata,
    output logic      o_mem_done,
    output word_t     o_mem_rdata,
    output logic      o_dp_arvalid,
    output addr_t     o_dp_araddr,
    output len_t      o_dp_arlen,
    input  logic      i_dp_arready,
    input  logic      i_dp_rvalid,
    input  word_t     i_dp_rdata,
    input  logic      i_dp_rlast,
    output logic      o_dp_rready,
    output logic      o_dp_awvalid,
    output addr_t     o_dp_awaddr,
    input  logic      i_dp_awready,
    output logic      o_dp_wvalid,
    output word_t     o_dp_wdata,
    output strb_t     o_dp_wstrb,
    input  logic      i_dp_wready,
    input  logic      i_dp_bvalid,
    output logic      o_dp_bready
);

    typedef enum logic [1:0] {
        DP_IDLE,
        DP_READ,
        DP_WRITE,
        DP_WRESP
    } dp_state_e;

    dp_state_e  state;
    logic       a_sent;
    logic       w_sent;
    logic [1:0] lane;
    logic       r_fire;
    logic       aw_fire;
    logic       w_fire;
    strb_t      strb;
    word_t      wlanes;

    function automatic word_t load_extend(word_t raw, logic [1:0] off, mem_type_e mt);
        word_t sh;
        sh = raw >> {off, 3'b000};
        case (mt)
            MT_B:    return {{24{sh[7]}}, sh[7:0]};
            MT_BU:   return {24'b0, sh[7:0]};
            MT_H:    return {{16{sh[15]}}, sh[15:0]};
            MT_HU:   return {16'b0, sh[15:0]};
            default: return sh;
        endcase
    endfunction

    assign lane = i_mem_addr[1:0];

    // replicate store data on every lane, strobes pick the bytes
    always_comb begin
        case (i_mem_type)
            MT_B, MT_BU: begin
                strb   = strb_t'(4'b0001 << lane);
                wlanes = {4{i_mem_wdata[7:0]}};
            end
            MT_H, MT_HU: begin
                strb   = strb_t'(4'b0011 << lane);
                wlanes = {2{i_mem_wdata[15:0]}};
            end
            default: begin
                strb   = 4'b1111;
                wlanes = i_mem_wdata;
            end
        endcase
    end

    assign o_dp_arvalid = (state == DP_READ) && !a_sent;
    assign o_dp_araddr  = {i_mem_addr[ADDR_W-1:2], 2'b00};
    assign o_dp_arlen   = '0;
    assign o_dp_rready  = (state == DP_READ) && a_sent;

    assign o_dp_awvalid = (state == DP_WRITE) && !a_sent;
    assign o_dp_awaddr  = {i_mem_addr[ADDR_W-1:2], 2'b00};
    assign o_dp_wvalid  = (state == DP_WRITE) && !w_sent;
    assign o_dp_wdata   = wlanes;
    assign o_dp_wstrb   = strb;
    assign o_dp_bready  = (state == DP_WRESP);

    assign r_fire  = i_dp_rvalid && o_dp_rready;
    assign aw_fire = o_dp_awvalid && i_dp_awready;
    assign w_fire  = o_dp_wvalid && i_dp_wready;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= DP_IDLE;
            a_sent     <= 1'b0;
            w_sent     <= 1'b0;
            o_mem_done <= 1'b0;
        end else begin
            o_mem_done <= 1'b0;
            case (state)
                DP_IDLE: begin
                    a_sent <= 1'b0;
                    w_sent <= 1'b0;
                    // the finished request is still held in its done cycle
                    if (i_mem_rd && !o_mem_done) begin
                        state <= DP_READ;
                    end else if (i_mem_wr && !o_mem_done) begin
                        state <= DP_WRITE;
                    end
                end
                DP_READ: begin
                    if (o_dp_arvalid && i_dp_arready) begin
                        a_sent <= 1'b1;
                    end
                    if (r_fire && i_dp_rlast) begin
                        o_mem_done <= 1'b1;
                        state      <= DP_IDLE;
                    end
                end
                DP_WRITE: begin
                    if (aw_fire) begin
                        a_sent <= 1'b1;
                    end
                    if (w_fire) begin
                        w_sent <= 1'b1;
                    end
                    // aw and w may be taken in either order
                    if ((a_sent || aw_fire) && (w_sent || w_fire)) begin
                        state <= DP_WRESP;
                    end
                end
                DP_WRESP: begin
                    if (i_dp_bvalid) begin
                        o_mem_done <= 1'b1;
                        state      <= DP_IDLE;
                    end
                end
                default: begin
                    state <= DP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (r_fire) begin
            o_mem_rdata <= load_extend(i_dp_rdata, lane, i_mem_type);
        end
    end

endmodule

//--- bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
    import mem_pkg::*;
#(
    parameter int LINE_WORDS = DEF_LINE_WORDS
) (
    input  logic  clk,
    input  logic  i_rst_n,
    // icache read master
    input  logic  i_ic_arvalid,
    input  addr_t i_ic_araddr,
    input  len_t  i_ic_arlen,
    input  logic  i_ic_rready,
    output logic  o_ic_arready,
    output logic  o_ic_rvalid,
    output word_t o_ic_rdata,
    output logic  o_ic_rlast,
    // data port read master
    input  logic  i_dp_arvalid,
    input  addr_t i_dp_araddr,
    input  len_t  i_dp_arlen,
    input  logic  i_dp_rready,
    output logic  o_dp_arready,
    output logic  o_dp_rvalid,
    output word_t o_dp_rdata,
    output logic  o_dp_rlast,
    // data port write master
    input  logic  i_dp_awvalid,
    input  addr_t i_dp_awaddr,
    input  logic  i_dp_wvalid,
    input  word_t i_dp_wdata,
    input  strb_t i_dp_wstrb,
    input  logic  i_dp_bready,
    output logic  o_dp_awready,
    output logic  o_dp_wready,
    output logic  o_dp_bvalid,
    // external bus
    output logic  o_arvalid,
    output addr_t o_araddr,
    output len_t  o_arlen,
    input  logic  i_arready,
    input  logic  i_rvalid,
    input  word_t i_rdata,
    input  logic  i_rlast,
    output logic  o_rready,
    output logic  o_awvalid,
    output addr_t o_awaddr,
    output len_t  o_awlen,
    input  logic  i_awready,
    output logic  o_wvalid,
    output word_t o_wdata,
    output strb_t o_wstrb,
    output logic  o_wlast,
    input  logic  i_wready,
    input  logic  i_bvalid,
    output logic  o_bready
);

    localparam int BEAT_W = $clog2(LINE_WORDS) + 1;

    typedef enum logic [1:0] {
        GNT_NONE,
        GNT_IC,
        GNT_DP
    } grant_e;

    grant_e            grant_q;
    grant_e            grant;
    logic              r_fire;
    // beats seen in the current burst
    logic [BEAT_W-1:0] r_beats;

    // data port first, loads stall the requester harder
    always_comb begin
        grant = grant_q;
        if (grant_q == GNT_NONE) begin
            if (i_dp_arvalid) begin
                grant = GNT_DP;
            end else if (i_ic_arvalid) begin
                grant = GNT_IC;
            end
        end
    end

    assign o_arvalid = (grant == GNT_DP) ? i_dp_arvalid :
                       (grant == GNT_IC) ? i_ic_arvalid : 1'b0;
    assign o_araddr  = (grant == GNT_DP) ? i_dp_araddr : i_ic_araddr;
    assign o_arlen   = (grant == GNT_DP) ? i_dp_arlen : i_ic_arlen;

    assign o_ic_arready = (grant == GNT_IC) && i_arready;
    assign o_dp_arready = (grant == GNT_DP) && i_arready;

    // r only flows to the master that owns the burst
    assign o_rready    = ((grant_q == GNT_IC) && i_ic_rready) ||
                         ((grant_q == GNT_DP) && i_dp_rready);
    assign o_ic_rvalid = (grant_q == GNT_IC) && i_rvalid;
    assign o_dp_rvalid = (grant_q == GNT_DP) && i_rvalid;
    assign o_ic_rdata  = i_rdata;
    assign o_dp_rdata  = i_rdata;
    assign o_ic_rlast  = i_rlast;
    assign o_dp_rlast  = i_rlast;

    assign r_fire = i_rvalid && o_rready;

    // writes belong to the data port alone, single beat
    assign o_awvalid    = i_dp_awvalid;
    assign o_awaddr     = i_dp_awaddr;
    assign o_awlen      = '0;
    assign o_wvalid     = i_dp_wvalid;
    assign o_wdata      = i_dp_wdata;
    assign o_wstrb      = i_dp_wstrb;
    assign o_wlast      = 1'b1;
    assign o_bready     = i_dp_bready;
    assign o_dp_awready = i_awready;
    assign o_dp_wready  = i_wready;
    assign o_dp_bvalid  = i_bvalid;

    // locked once ar is presented so its payload cannot switch
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            grant_q <= GNT_NONE;
            r_beats <= '0;
        end else begin
            if (grant_q == GNT_NONE) begin
                grant_q <= grant;
            end else if (r_fire && i_rlast) begin
                grant_q <= GNT_NONE;
            end
            if (r_fire) begin
                r_beats <= i_rlast ? '0 : r_beats + 1'b1;
            end
        end
    end

endmodule

//--- mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top
    import mem_pkg::*;
#(
    parameter int LINE_WORDS = DEF_LINE_WORDS,
    parameter int NUM_LINES  = DEF_NUM_LINES
) (
    input  logic        clk,
    input  logic        i_rst_n,
    // fetch side
    input  logic        i_if_req,
    input  addr_t       i_if_addr,
    output logic        o_if_valid,
    output fetch_pair_t o_if_data,
    // data side
    input  logic        i_mem_rd,
    input  logic        i_mem_wr,
    input  addr_t       i_mem_addr,
    input  mem_type_e   i_mem_type,
    input  word_t       i_mem_wdata,
    output logic        o_mem_done,
    output word_t       o_mem_rdata,
    // external bus
    output logic        o_arvalid,
    output addr_t       o_araddr,
    output len_t        o_arlen,
    input  logic        i_arready,
    input  logic        i_rvalid,
    input  word_t       i_rdata,
    input  logic        i_rlast,
    output logic        o_rready,
    output logic        o_awvalid,
    output addr_t       o_awaddr,
    output len_t        o_awlen,
    input  logic        i_awready,
    output logic        o_wvalid,
    output word_t       o_wdata,
    output strb_t       o_wstrb,
    output logic        o_wlast,
    input  logic        i_wready,
    input  logic        i_bvalid,
    output logic        o_bready
);

    logic  ic_arvalid;
    addr_t ic_araddr;
    len_t  ic_arlen;
    logic  ic_arready;
    logic  ic_rvalid;
    word_t ic_rdata;
    logic  ic_rlast;
    logic  ic_rready;

    logic  dp_arvalid;
    addr_t dp_araddr;
    len_t  dp_arlen;
    logic  dp_arready;
    logic  dp_rvalid;
    word_t dp_rdata;
    logic  dp_rlast;
    logic  dp_rready;
    logic  dp_awvalid;
    addr_t dp_awaddr;
    logic  dp_awready;
    logic  dp_wvalid;
    word_t dp_wdata;
    strb_t dp_wstrb;
    logic  dp_wready;
    logic  dp_bvalid;
    logic  dp_bready;

    icache #(
        .LINE_WORDS(LINE_WORDS),
        .NUM_LINES (NUM_LINES)
    ) icache_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_if_req    (i_if_req),
        .i_if_addr   (i_if_addr),
        .o_if_valid  (o_if_valid),
        .o_if_data   (o_if_data),
        .o_ic_arvalid(ic_arvalid),
        .o_ic_araddr (ic_araddr),
        .o_ic_arlen  (ic_arlen),
        .i_ic_arready(ic_arready),
        .i_ic_rvalid (ic_rvalid),
        .i_ic_rdata  (ic_rdata),
        .i_ic_rlast  (ic_rlast),
        .o_ic_rready (ic_rready)
    );

    data_port data_port_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_mem_rd    (i_mem_rd),
        .i_mem_wr    (i_mem_wr),
        .i_mem_addr  (i_mem_addr),
        .i_mem_type  (i_mem_type),
        .i_mem_wdata (i_mem_wdata),
        .o_mem_done  (o_mem_done),
        .o_mem_rdata (o_mem_rdata),
        .o_dp_arvalid(dp_arvalid),
        .o_dp_araddr (dp_araddr),
        .o_dp_arlen  (dp_arlen),
        .i_dp_arready(dp_arready),
        .i_dp_rvalid (dp_rvalid),
        .i_dp_rdata  (dp_rdata),
        .i_dp_rlast  (dp_rlast),
        .o_dp_rready (dp_rready),
        .o_dp_awvalid(dp_awvalid),
        .o_dp_awaddr (dp_awaddr),
        .i_dp_awready(dp_awready),
        .o_dp_wvalid (dp_wvalid),
        .o_dp_wdata  (dp_wdata),
        .o_dp_wstrb  (dp_wstrb),
        .i_dp_wready (dp_wready),
        .i_dp_bvalid (dp_bvalid),
        .o_dp_bready (dp_bready)
    );

    bus_arbiter #(
        .LINE_WORDS(LINE_WORDS)
    ) bus_arbiter_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_ic_arvalid(ic_arvalid),
        .i_ic_araddr (ic_araddr),
        .i_ic_arlen  (ic_arlen),
        .i_ic_rready (ic_rready),
        .o_ic_arready(ic_arready),
        .o_ic_rvalid (ic_rvalid),
        .o_ic_rdata  (ic_rdata),
        .o_ic_rlast  (ic_rlast),
        .i_dp_arvalid(dp_arvalid),
        .i_dp_araddr (dp_araddr),
        .i_dp_arlen  (dp_arlen),
        .i_dp_rready (dp_rready),
        .o_dp_arready(dp_arready),
        .o_dp_rvalid (dp_rvalid),
        .o_dp_rdata  (dp_rdata),
        .o_dp_rlast  (dp_rlast),
        .i_dp_awvalid(dp_awvalid),
        .i_dp_awaddr (dp_awaddr),
        .i_dp_wvalid (dp_wvalid),
        .i_dp_wdata  (dp_wdata),
        .i_dp_wstrb  (dp_wstrb),
        .i_dp_bready (dp_bready),
        .o_dp_awready(dp_awready),
        .o_dp_wready (dp_wready),
        .o_dp_bvalid (dp_bvalid),
        .o_arvalid   (o_arvalid),
        .o_araddr    (o_araddr),
        .o_arlen     (o_arlen),
        .i_arready   (i_arready),
        .i_rvalid    (i_rvalid),
        .i_rdata     (i_rdata),
        .i_rlast     (i_rlast),
        .o_rready    (o_rready),
        .o_awvalid   (o_awvalid),
        .o_awaddr    (o_awaddr),
        .o_awlen     (o_awlen),
        .i_awready   (i_awready),
        .o_wvalid    (o_wvalid),
        .o_wdata     (o_wdata),
        .o_wstrb     (o_wstrb),
        .o_wlast     (o_wlast),
        .i_wready    (i_wready),
        .i_bvalid    (i_bvalid),
        .o_bready    (o_bready)
    );

endmodule

//--- tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 10
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

//--- tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  i_rand_en,
    input  logic  i_arvalid,
    input  addr_t i_araddr,
    input  len_t  i_arlen,
    output logic  o_arready,
    output logic  o_rvalid,
    output word_t o_rdata,
    output logic  o_rlast,
    input  logic  i_rready,
    input  logic  i_awvalid,
    input  addr_t i_awaddr,
    output logic  o_awready,
    input  logic  i_wvalid,
    input  word_t i_wdata,
    input  strb_t i_wstrb,
    output logic  o_wready,
    output logic  o_bvalid,
    input  logic  i_bready
);

    integer seed = 32'h7364;
    word_t  mem [1024];

    // 4 KB window, the word index wraps
    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = (32'(i) * 32'h0101_0104) ^ 32'hC3A5_5A3C;
        end
    end

    function automatic int pick_delay();
        int d;
        d = 0;
        if (i_rand_en) begin
            d = $random(seed) & 3;
        end
        return d;
    endfunction

    // read channel, bursts of arlen + 1 beats
    initial begin
        logic [9:0] wi;
        len_t       len;
        o_arready = 1'b0;
        o_rvalid  = 1'b0;
        o_rdata   = '0;
        o_rlast   = 1'b0;
        forever begin
            @(negedge clk);
            if (i_arvalid) begin
                repeat (pick_delay()) @(negedge clk);
                o_arready = 1'b1;
                @(posedge clk);
                wi  = i_araddr[11:2];
                len = i_arlen;
                @(negedge clk);
                o_arready = 1'b0;
                for (int b = 0; b <= int'(len); b++) begin
                    repeat (pick_delay()) @(negedge clk);
                    o_rvalid = 1'b1;
                    o_rdata  = mem[wi];
                    o_rlast  = (b == int'(len));
                    do @(posedge clk); while (!i_rready);
                    @(negedge clk);
                    o_rvalid = 1'b0;
                    o_rlast  = 1'b0;
                    wi       = wi + 10'd1;
                end
            end
        end
    end

    // write channels, aw first, then w, then b
    initial begin
        logic [9:0] wi;
        word_t      wd;
        strb_t      ws;
        o_awready = 1'b0;
        o_wready  = 1'b0;
        o_bvalid  = 1'b0;
        forever begin
            @(negedge clk);
            if (i_awvalid) begin
                repeat (pick_delay()) @(negedge clk);
                o_awready = 1'b1;
                @(posedge clk);
                wi = i_awaddr[11:2];
                @(negedge clk);
                o_awready = 1'b0;
                while (!i_wvalid) @(negedge clk);
                repeat (pick_delay()) @(negedge clk);
                o_wready = 1'b1;
                @(posedge clk);
                wd = i_wdata;
                ws = i_wstrb;
                @(negedge clk);
                o_wready = 1'b0;
                for (int i = 0; i < 4; i++) begin
                    if (ws[i]) begin
                        mem[wi][8*i +: 8] = wd[8*i +: 8];
                    end
                end
                repeat (pick_delay()) @(negedge clk);
                o_bvalid = 1'b1;
                do @(posedge clk); while (!i_bready);
                @(negedge clk);
                o_bvalid = 1'b0;
            end
        end
    end

endmodule

//--- mem_props.sv
`timescale 1ns/1ps

module mem_props #(
    parameter int LINE_WORDS = 4
) (
    input logic       clk,
    input logic       i_rst_n,
    input logic       i_arvalid,
    input logic [31:0] i_araddr,
    input logic       i_arready,
    input logic       i_rvalid,
    input logic       i_rready,
    input logic       i_rlast,
    input logic       i_ic_rready,
    input logic       i_dp_rready,
    input logic       i_awvalid,
    input logic       i_awready,
    input logic [1:0] i_grant_q,
    input logic [$clog2(LINE_WORDS):0] i_r_beats
);

    ar_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
        else $error("ar request dropped or changed before arready");

    // grant encoding is 1 for icache and 2 for data port
    rready_granted: assert property (@(posedge clk) disable iff (!i_rst_n)
        (!i_ic_rready || i_grant_q == 2'd1) && (!i_dp_rready || i_grant_q == 2'd2))
        else $error("a read master raised rready without holding the read grant");

    aw_held: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_awvalid && !i_awready |=> i_awvalid)
        else $error("write address withdrawn before awready");

    burst_len: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_rvalid && i_rready && i_rlast |-> int'(i_r_beats) <= LINE_WORDS - 1)
        else $error("read burst longer than a cache line");

endmodule

bind bus_arbiter mem_props #(
    .LINE_WORDS(LINE_WORDS)
) mem_props_i (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_arvalid  (o_arvalid),
    .i_araddr   (o_araddr),
    .i_arready  (i_arready),
    .i_rvalid   (i_rvalid),
    .i_rready   (o_rready),
    .i_rlast    (i_rlast),
    .i_ic_rready(i_ic_rready),
    .i_dp_rready(i_dp_rready),
    .i_awvalid  (o_awvalid),
    .i_awready  (i_awready),
    .i_grant_q  (grant_q),
    .i_r_beats  (r_beats)
);

//--- tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys
    import mem_pkg::*;
();

    localparam int N_REQ       = 32;
    localparam int WATCHDOG_NS = (10 + 200 * N_REQ) * 100;

    logic clk, rst_n, rand_en;
    logic i_if_req, o_if_valid;
    addr_t i_if_addr;
    fetch_pair_t o_if_data;
    logic i_mem_rd, i_mem_wr, o_mem_done;
    addr_t i_mem_addr;
    mem_type_e i_mem_type;
    word_t i_mem_wdata, o_mem_rdata;
    logic arvalid, arready, rvalid, rlast, rready;
    logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    addr_t araddr, awaddr;
    len_t arlen, awlen;
    word_t rdata, wdata;
    strb_t wstrb;

    word_t shadow [1024];
    fetch_pair_t exp_pair;
    word_t exp_load;
    logic load_pending;
    int n_checks, n_errors;

    tb_clkgen clkgen_i (.o_clk(clk), .o_rst_n(rst_n));

    mem_subsys_top #(
        .LINE_WORDS(DEF_LINE_WORDS),
        .NUM_LINES (DEF_NUM_LINES)
    ) dut_i (
        .clk(clk), .i_rst_n(rst_n),
        .i_if_req(i_if_req), .i_if_addr(i_if_addr),
        .o_if_valid(o_if_valid), .o_if_data(o_if_data),
        .i_mem_rd(i_mem_rd), .i_mem_wr(i_mem_wr), .i_mem_addr(i_mem_addr),
        .i_mem_type(i_mem_type), .i_mem_wdata(i_mem_wdata),
        .o_mem_done(o_mem_done), .o_mem_rdata(o_mem_rdata),
        .o_arvalid(arvalid), .o_araddr(araddr), .o_arlen(arlen), .i_arready(arready),
        .i_rvalid(rvalid), .i_rdata(rdata), .i_rlast(rlast), .o_rready(rready),
        .o_awvalid(awvalid), .o_awaddr(awaddr), .o_awlen(awlen), .i_awready(awready),
        .o_wvalid(wvalid), .o_wdata(wdata), .o_wstrb(wstrb), .o_wlast(wlast),
        .i_wready(wready), .i_bvalid(bvalid), .o_bready(bready)
    );

    tb_axi_mem mem_i (
        .clk(clk), .i_rand_en(rand_en),
        .i_arvalid(arvalid), .i_araddr(araddr), .i_arlen(arlen), .o_arready(arready),
        .o_rvalid(rvalid), .o_rdata(rdata), .o_rlast(rlast), .i_rready(rready),
        .i_awvalid(awvalid), .i_awaddr(awaddr), .o_awready(awready),
        .i_wvalid(wvalid), .i_wdata(wdata), .i_wstrb(wstrb), .o_wready(wready),
        .o_bvalid(bvalid), .i_bready(bready)
    );

    function automatic int widx(addr_t a);
        return int'(a[11:2]);
    endfunction

    function automatic fetch_pair_t expected_pair(addr_t a);
        return {shadow[widx(a) + 1], shadow[widx(a)]};
    endfunction

    function automatic word_t expected_load(addr_t a, mem_type_e t);
        word_t w;
        int off;
        w   = shadow[widx(a)];
        off = int'(a[1:0]) * 8;
        case (t)
            MT_B:    return {{24{w[off+7]}}, w[off +: 8]};
            MT_BU:   return {24'b0, w[off +: 8]};
            MT_H:    return {{16{w[off+15]}}, w[off +: 16]};
            MT_HU:   return {16'b0, w[off +: 16]};
            default: return w;
        endcase
    endfunction

    function automatic word_t expected_store(addr_t a, mem_type_e t, word_t d);
        word_t w;
        int off;
        w   = shadow[widx(a)];
        off = int'(a[1:0]) * 8;
        case (t)
            MT_B, MT_BU: w[off +: 8] = d[7:0];
            MT_H, MT_HU: w[off +: 16] = d[15:0];
            default:     w = d;
        endcase
        return w;
    endfunction

    task automatic do_fetch(input addr_t a, input bit expect_hit);
        int cyc;
        exp_pair  = expected_pair(a);
        i_if_req  = 1'b1;
        i_if_addr = a;
        cyc       = 0;
        do begin
            @(negedge clk);
            cyc++;
        end while (!o_if_valid);
        i_if_req = 1'b0;
        if (expect_hit) begin
            n_checks++;
            assert (cyc == 1) else begin
                n_errors++;
                $display("[ERROR] %0t hit at %h took %0d cycles", $time, a, cyc);
            end
        end
        // next request starts in the following cycle
        @(negedge clk);
    endtask

    task automatic do_mem(input bit wr, input addr_t a, input mem_type_e t, input word_t d);
        load_pending = !wr;
        if (!wr) begin
            exp_load = expected_load(a, t);
        end
        i_mem_rd    = !wr;
        i_mem_wr    = wr;
        i_mem_addr  = a;
        i_mem_type  = t;
        i_mem_wdata = d;
        do @(negedge clk); while (!o_mem_done);
        i_mem_rd = 1'b0;
        i_mem_wr = 1'b0;
        if (wr) begin
            shadow[widx(a)] = expected_store(a, t, d);
        end
        @(negedge clk);
    endtask

    task automatic run_suite(input addr_t base);
        do_fetch(base + 32'h100, 1'b0);
        do_fetch(base + 32'h108, 1'b1);
        do_mem(1'b1, base + 32'h40, MT_W, 32'h89AB_CDEF);
        do_mem(1'b1, base + 32'h46, MT_H, 32'h0000_F00D);
        do_mem(1'b1, base + 32'h41, MT_B, 32'h0000_00A5);
        do_mem(1'b1, base + 32'h4B, MT_BU, 32'h0000_007E);
        do_mem(1'b0, base + 32'h41, MT_B, '0);
        do_mem(1'b0, base + 32'h41, MT_BU, '0);
        do_mem(1'b0, base + 32'h46, MT_H, '0);
        do_mem(1'b0, base + 32'h46, MT_HU, '0);
        do_mem(1'b0, base + 32'h40, MT_W, '0);
        do_mem(1'b0, base + 32'h4B, MT_B, '0);
        do_mem(1'b0, base + 32'h44, MT_HU, '0);
        do_mem(1'b0, base + 32'h43, MT_BU, '0);
        // miss and load race for the read channel
        fork
            do_fetch(base + 32'h180, 1'b0);
            do_mem(1'b0, base + 32'h48, MT_W, '0);
        join
    endtask

    // compares on the falling edge where outputs are settled
    always @(negedge clk) begin
        if (o_if_valid) begin
            n_checks++;
            assert (o_if_data == exp_pair) else begin
                n_errors++;
                $display("[ERROR] %0t fetch %h got %h expected %h",
                         $time, i_if_addr, o_if_data, exp_pair);
            end
        end
        if (o_mem_done && load_pending) begin
            n_checks++;
            assert (o_mem_rdata == exp_load) else begin
                n_errors++;
                $display("[ERROR] %0t load %h type %0d got %h expected %h",
                         $time, i_mem_addr, i_mem_type, o_mem_rdata, exp_load);
            end
        end
        // writes are single beat
        if (awvalid || wvalid) begin
            n_checks++;
            assert (awlen == '0 && wlast) else begin
                n_errors++;
                $display("[ERROR] %0t write burst awlen %0d wlast %b",
                         $time, awlen, wlast);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: requests did not complete in the allowed time");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        i_if_req     = 1'b0;
        i_if_addr    = '0;
        i_mem_rd     = 1'b0;
        i_mem_wr     = 1'b0;
        i_mem_addr   = '0;
        i_mem_type   = MT_W;
        i_mem_wdata  = '0;
        rand_en      = 1'b0;
        load_pending = 1'b0;
        exp_pair     = '0;
        exp_load     = '0;
        n_checks     = 0;
        n_errors     = 0;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = (32'(i) * 32'h0101_0104) ^ 32'hC3A5_5A3C;
        end
        // quiet through reset and a little after
        repeat (12) begin
            @(negedge clk);
            n_checks++;
            assert (!o_if_valid && !o_mem_done && !arvalid && !awvalid && !wvalid &&
                    !rready && !bready) else begin
                n_errors++;
                $display("[ERROR] %0t bus or done active without a request", $time);
            end
        end
        run_suite(32'h0);
        rand_en = 1'b1;
        run_suite(32'h400);
        repeat (4) @(negedge clk);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- tb.f
mem_pkg.sv
icache.sv
data_port.sv
bus_arbiter.sv
mem_subsys_top.sv
tb_clkgen.sv
tb_axi_mem.sv
mem_props.sv
tb_mem_subsys.sv

//--- run.sh
#!/bin/sh
# compile and run with Verilator, the log decides the result
verilator --binary --timing --assert --top-module tb_mem_subsys \
    -f tb.f -o sim_mem_subsys > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_mem_subsys > sim.log 2>&1
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; } \
    || grep -q "Done: no errors" sim.log && echo "PASS" \
    || { echo "FAIL"; exit 1; }
